// ==== hw/ifu_pkg.sv ====
package ifu_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;

  // direct-mapped icache geometry
  localparam int ICACHE_SETS = 4;
  localparam int LINE_WORDS = 2;
  localparam int OFF_W = 1;
  localparam int IDX_W = 2;
  localparam int TAG_W = XLEN - IDX_W - OFF_W - 2;

  // rv32i major opcodes
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD = 7'b0000011;

  // fence.i with rd = rs1 = 0, imm = 0
  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  typedef enum logic [1:0] {
    CLASS_SEQ = 2'd0,
    CLASS_CTRL = 2'd1,
    CLASS_LOAD = 2'd2,
    CLASS_FENCE = 2'd3
  } inst_class_e;

endpackage

// ==== hw/ifu_axil_reader.sv ====
`timescale 1ns/1ps

module ifu_axil_reader import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_valid_i,
  input  logic [XLEN-1:0] req_addr_i,
  output logic            rsp_valid_o,
  output logic [XLEN-1:0] rsp_data_o,
  output logic [XLEN-1:0] araddr_o,
  output logic            arvalid_o,
  output logic            rready_o,
  input  logic            arready_i,
  input  logic [XLEN-1:0] rdata_i,
  input  logic            rvalid_i
);

  typedef enum logic [1:0] {
    RD_IDLE = 2'd0,
    RD_ADDR = 2'd1,
    RD_DATA = 2'd2
  } rd_state_e;

  rd_state_e state_q;
  logic [XLEN-1:0] addr_q;

  // a request still high during the response pulse is the old one
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RD_IDLE;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= 1'b0;
      case (state_q)
        RD_IDLE: begin
          if (req_valid_i && !rsp_valid_o) begin
            state_q <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (arready_i) begin
            state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (rvalid_i) begin
            state_q <= RD_IDLE;
            rsp_valid_o <= 1'b1;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == RD_IDLE) begin
      addr_q <= req_addr_i;
    end
    if (state_q == RD_DATA && rvalid_i) begin
      rsp_data_o <= rdata_i;
    end
  end

  assign araddr_o = addr_q;
  assign arvalid_o = (state_q == RD_ADDR);
  assign rready_o = (state_q == RD_DATA);

endmodule

// ==== hw/ifu_icache.sv ====
`timescale 1ns/1ps

module ifu_icache import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [XLEN-1:0] fetch_pc_i,
  input  logic            flush_i,
  output logic            hit_o,
  output logic [XLEN-1:0] hit_inst_o,
  output logic            req_valid_o,
  output logic [XLEN-1:0] req_addr_o,
  input  logic            rsp_valid_i,
  input  logic [XLEN-1:0] rsp_data_i
);

  typedef enum logic {
    C_IDLE = 1'b0,
    C_FILL = 1'b1
  } cache_state_e;

  cache_state_e state_q;

  logic [XLEN-1:0]        data_q [ICACHE_SETS][LINE_WORDS];
  logic [TAG_W-1:0]       tag_q [ICACHE_SETS];
  logic [ICACHE_SETS-1:0] valid_q;

  logic [TAG_W-1:0] pc_tag;
  logic [IDX_W-1:0] pc_idx;
  logic [OFF_W-1:0] pc_off;

  logic [XLEN-1:0]  fill_addr_q;
  logic [TAG_W-1:0] fill_tag;
  logic [IDX_W-1:0] fill_idx;
  logic [OFF_W-1:0] fill_off;
  logic             fill_last;
  logic             miss_start;

  assign pc_tag = fetch_pc_i[XLEN-1 -: TAG_W];
  assign pc_idx = fetch_pc_i[OFF_W+2 +: IDX_W];
  assign pc_off = fetch_pc_i[2 +: OFF_W];

  assign fill_tag = fill_addr_q[XLEN-1 -: TAG_W];
  assign fill_idx = fill_addr_q[OFF_W+2 +: IDX_W];
  assign fill_off = fill_addr_q[2 +: OFF_W];
  assign fill_last = (fill_off == OFF_W'(LINE_WORDS - 1));

  // lookup only reported while no refill is running
  assign hit_o = (state_q == C_IDLE) && valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign hit_inst_o = data_q[pc_idx][pc_off];

  assign miss_start = (state_q == C_IDLE) && !hit_o && !flush_i;

  assign req_valid_o = (state_q == C_FILL);
  assign req_addr_o = fill_addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= C_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        C_IDLE: begin
          if (flush_i) begin
            valid_q <= '0;
          end else if (miss_start) begin
            // line goes invalid until its last word lands
            valid_q[pc_idx] <= 1'b0;
            state_q <= C_FILL;
          end
        end
        C_FILL: begin
          if (rsp_valid_i && fill_last) begin
            valid_q[fill_idx] <= 1'b1;
            state_q <= C_IDLE;
          end
        end
        default: state_q <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) begin
      fill_addr_q <= {fetch_pc_i[XLEN-1:OFF_W+2], {OFF_W{1'b0}}, 2'b00};
    end else if (state_q == C_FILL && rsp_valid_i) begin
      data_q[fill_idx][fill_off] <= rsp_data_i;
      fill_addr_q <= fill_addr_q + XLEN'(4);
      if (fill_last) begin
        tag_q[fill_idx] <= fill_tag;
      end
    end
  end

endmodule

// ==== hw/ifu_fetch_ctrl.sv ====
`timescale 1ns/1ps

module ifu_fetch_ctrl import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            redirect_valid_i,
  input  logic            redirect_taken_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic            lsu_done_i,
  output logic [XLEN-1:0] fetch_pc_o,
  output logic            flush_o,
  input  logic            hit_i,
  input  logic [XLEN-1:0] hit_inst_i,
  output logic            push_valid_o,
  output logic [XLEN-1:0] push_pc_o,
  output logic [XLEN-1:0] push_inst_o,
  input  logic            push_ready_i
);

  typedef enum logic [1:0] {
    F_RUN = 2'd0,
    F_WAIT_CTRL = 2'd1,
    F_WAIT_LOAD = 2'd2
  } fetch_state_e;

  fetch_state_e state_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next_seq;
  logic [6:0] opcode;
  inst_class_e inst_class;
  logic accept;

  // predecode of the word under lookup
  assign opcode = hit_inst_i[6:0];

  always_comb begin
    if (hit_inst_i == INST_FENCE_I) begin
      inst_class = CLASS_FENCE;
    end else if (opcode == OP_JAL || opcode == OP_JALR ||
                 opcode == OP_BRANCH || opcode == OP_SYSTEM) begin
      inst_class = CLASS_CTRL;
    end else if (opcode == OP_LOAD) begin
      inst_class = CLASS_LOAD;
    end else begin
      inst_class = CLASS_SEQ;
    end
  end

  assign pc_next_seq = pc_q + XLEN'(4);

  assign fetch_pc_o = pc_q;
  assign push_valid_o = (state_q == F_RUN) && hit_i;
  assign push_pc_o = pc_q;
  assign push_inst_o = hit_inst_i;
  assign accept = push_valid_o && push_ready_i;
  assign flush_o = accept && (inst_class == CLASS_FENCE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= F_RUN;
      pc_q <= PC_INIT;
    end else begin
      case (state_q)
        F_RUN: begin
          if (accept) begin
            case (inst_class)
              CLASS_CTRL: state_q <= F_WAIT_CTRL;
              CLASS_LOAD: state_q <= F_WAIT_LOAD;
              default: pc_q <= pc_next_seq;
            endcase
          end
        end
        F_WAIT_CTRL: begin
          if (redirect_valid_i) begin
            pc_q <= redirect_taken_i ? redirect_pc_i : pc_next_seq;
            state_q <= F_RUN;
          end
        end
        F_WAIT_LOAD: begin
          if (lsu_done_i) begin
            pc_q <= pc_next_seq;
            state_q <= F_RUN;
          end
        end
        default: state_q <= F_RUN;
      endcase
    end
  end

endmodule

// ==== hw/ifu_inst_buffer.sv ====
`timescale 1ns/1ps

module ifu_inst_buffer import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            push_valid_i,
  input  logic [XLEN-1:0] push_pc_i,
  input  logic [XLEN-1:0] push_inst_i,
  output logic            push_ready_o,
  output logic            dec_valid_o,
  output logic [XLEN-1:0] dec_pc_o,
  output logic [XLEN-1:0] dec_inst_o,
  input  logic            dec_ready_i
);

  logic [XLEN-1:0] pc_mem [2];
  logic [XLEN-1:0] inst_mem [2];
  logic            rd_ptr_q;
  logic            wr_ptr_q;
  logic [1:0]      count_q;
  logic            do_push;
  logic            do_pop;

  assign push_ready_o = (count_q != 2'd2);
  assign dec_valid_o = (count_q != 2'd0);
  assign dec_pc_o = pc_mem[rd_ptr_q];
  assign dec_inst_o = inst_mem[rd_ptr_q];

  assign do_push = push_valid_i && push_ready_o;
  assign do_pop = dec_valid_o && dec_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q <= 2'd0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (do_pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 2'd1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      pc_mem[wr_ptr_q] <= push_pc_i;
      inst_mem[wr_ptr_q] <= push_inst_i;
    end
  end

endmodule

// ==== hw/ifu_top.sv ====
`timescale 1ns/1ps

module ifu_top import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  output logic [XLEN-1:0] araddr_o,
  output logic            arvalid_o,
  input  logic            arready_i,
  input  logic [XLEN-1:0] rdata_i,
  input  logic            rvalid_i,
  output logic            rready_o,
  output logic            dec_valid_o,
  input  logic            dec_ready_i,
  output logic [XLEN-1:0] dec_pc_o,
  output logic [XLEN-1:0] dec_inst_o,
  input  logic            redirect_valid_i,
  input  logic            redirect_taken_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic            lsu_done_i
);

  logic            req_valid;
  logic [XLEN-1:0] req_addr;
  logic            rsp_valid;
  logic [XLEN-1:0] rsp_data;
  logic [XLEN-1:0] fetch_pc;
  logic            flush;
  logic            hit;
  logic [XLEN-1:0] hit_inst;
  logic            push_valid;
  logic [XLEN-1:0] push_pc;
  logic [XLEN-1:0] push_inst;
  logic            push_ready;

  // bus side
  ifu_axil_reader u_reader (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_addr_i  (req_addr),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data),
    .araddr_o    (araddr_o),
    .arvalid_o   (arvalid_o),
    .rready_o    (rready_o),
    .arready_i   (arready_i),
    .rdata_i     (rdata_i),
    .rvalid_i    (rvalid_i)
  );

  ifu_icache u_icache (
    .clk         (clk),
    .rst         (rst),
    .fetch_pc_i  (fetch_pc),
    .flush_i     (flush),
    .hit_o       (hit),
    .hit_inst_o  (hit_inst),
    .req_valid_o (req_valid),
    .req_addr_o  (req_addr),
    .rsp_valid_i (rsp_valid),
    .rsp_data_i  (rsp_data)
  );

  ifu_fetch_ctrl u_fetch_ctrl (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_taken_i (redirect_taken_i),
    .redirect_pc_i    (redirect_pc_i),
    .lsu_done_i       (lsu_done_i),
    .fetch_pc_o       (fetch_pc),
    .flush_o          (flush),
    .hit_i            (hit),
    .hit_inst_i       (hit_inst),
    .push_valid_o     (push_valid),
    .push_pc_o        (push_pc),
    .push_inst_o      (push_inst),
    .push_ready_i     (push_ready)
  );

  // decode side
  ifu_inst_buffer u_inst_buffer (
    .clk          (clk),
    .rst          (rst),
    .push_valid_i (push_valid),
    .push_pc_i    (push_pc),
    .push_inst_i  (push_inst),
    .push_ready_o (push_ready),
    .dec_valid_o  (dec_valid_o),
    .dec_pc_o     (dec_pc_o),
    .dec_inst_o   (dec_inst_o),
    .dec_ready_i  (dec_ready_i)
  );

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_o
);

  initial clk_o = 1'b0;
  always #10 clk_o = ~clk_o;

  // reset held for 16 rising edges
  initial begin
    rst_o <= 1'b1;
    repeat (16) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== verif/tb_ifu_checker.sv ====
`timescale 1ns/1ps

module tb_ifu_checker import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            dec_valid_i,
  input  logic            dec_ready_i,
  input  logic [XLEN-1:0] dec_pc_i,
  input  logic [XLEN-1:0] dec_inst_i,
  input  logic [XLEN-1:0] araddr_i,
  input  logic            arvalid_i,
  input  logic            arready_i,
  input  logic            rvalid_i,
  input  logic            rready_i,
  input  logic            redirect_valid_i,
  input  logic            lsu_done_i,
  output logic            done_o,
  output int              data_errs_o,
  output int              proto_errs_o,
  output int              ar_count_o
);

  logic [XLEN-1:0] exp_pc [$];
  logic [XLEN-1:0] exp_inst [$];
  string           exp_name [$];
  int              exp_reads = 0;
  int              seen = 0;
  int              data_errs = 0;
  int              proto_errs = 0;
  int              ar_count = 0;
  logic            done_q = 1'b0;
  logic            held_q = 1'b0;
  logic [XLEN-1:0] held_pc;
  logic [XLEN-1:0] held_inst;
  logic            ar_wait_q = 1'b0;
  logic [XLEN-1:0] ar_addr_q;
  logic            r_open = 1'b0;
  inst_class_e     stall_kind = CLASS_SEQ;

  assign done_o = done_q;
  assign data_errs_o = data_errs;
  assign proto_errs_o = proto_errs;
  assign ar_count_o = ar_count;

  task automatic add_expected(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] inst,
                              input string name);
    exp_pc.push_back(pc);
    exp_inst.push_back(inst);
    exp_name.push_back(name);
  endtask

  task automatic set_reads(input int reads);
    exp_reads = reads;
  endtask

  function automatic inst_class_e classify(input logic [XLEN-1:0] inst);
    if (inst == INST_FENCE_I) begin
      return CLASS_FENCE;
    end
    case (inst[6:0])
      OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM: return CLASS_CTRL;
      OP_LOAD: return CLASS_LOAD;
      default: return CLASS_SEQ;
    endcase
  endfunction

  always @(posedge clk) begin
    logic        xfer;
    inst_class_e dec_class;
    xfer = dec_valid_i && dec_ready_i;
    if (!rst) begin
      // address must hold until the slave takes it
      if (ar_wait_q && (!arvalid_i || araddr_i != ar_addr_q)) begin
        proto_errs++;
        $display("read address %h changed or was withdrawn before arready", ar_addr_q);
      end
      if (rready_i != r_open) begin
        proto_errs++;
        $display("rready was %b while a read %s outstanding", rready_i,
                 r_open ? "was" : "was not");
      end
      if (arvalid_i && arready_i) begin
        ar_count++;
        r_open = 1'b1;
      end
      if (rvalid_i && rready_i) begin
        r_open = 1'b0;
      end
      // a held item must stay put until decode takes it
      if (held_q && (!dec_valid_i || dec_pc_i != held_pc || dec_inst_i != held_inst)) begin
        proto_errs++;
        $display("decode item at pc %h changed or dropped while it was held", held_pc);
      end
      if (xfer && stall_kind != CLASS_SEQ) begin
        proto_errs++;
        $display("decode transfer at pc %h came before the stall was released", dec_pc_i);
      end
      if ((stall_kind == CLASS_CTRL && redirect_valid_i) ||
          (stall_kind == CLASS_LOAD && lsu_done_i)) begin
        stall_kind = CLASS_SEQ;
      end
      if (xfer) begin
        if (seen < exp_pc.size()) begin
          if (dec_pc_i != exp_pc[seen]) begin
            data_errs++;
            $display("ERR %s pc: expected %h, actual %h", exp_name[seen], exp_pc[seen],
                     dec_pc_i);
          end
          if (dec_inst_i != exp_inst[seen]) begin
            data_errs++;
            $display("ERR %s inst: expected %h, actual %h", exp_name[seen], exp_inst[seen],
                     dec_inst_i);
          end
          seen++;
          if (seen == exp_pc.size()) begin
            // fetch is parked on the final load, so the read count is settled
            if (ar_count != exp_reads) begin
              data_errs++;
              $display("ERR ar_count: expected %0d, actual %0d", exp_reads, ar_count);
            end
            done_q <= 1'b1;
          end
        end else begin
          proto_errs++;
          $display("decode transfer at pc %h came after the expected stream ended", dec_pc_i);
        end
        dec_class = classify(dec_inst_i);
        if (dec_class == CLASS_CTRL || dec_class == CLASS_LOAD) begin
          stall_kind = dec_class;
        end
      end
      held_q <= dec_valid_i && !dec_ready_i;
      held_pc <= dec_pc_i;
      held_inst <= dec_inst_i;
      ar_wait_q <= arvalid_i && !arready_i;
      ar_addr_q <= araddr_i;
    end
  end

endmodule

// ==== verif/tb_ifu.sv ====
`timescale 1ns/1ps

module tb_ifu import ifu_pkg::*; ();

  localparam int N_PROG = 16;
  localparam int N_RESP = 9;

  logic            clk;
  logic            rst;
  logic [XLEN-1:0] araddr_o;
  logic            arvalid_o;
  logic            arready_i = 1'b0;
  logic [XLEN-1:0] rdata_i = '0;
  logic            rvalid_i = 1'b0;
  logic            rready_o;
  logic            dec_valid_o;
  logic            dec_ready_i = 1'b0;
  logic [XLEN-1:0] dec_pc_o;
  logic [XLEN-1:0] dec_inst_o;
  logic            redirect_valid_i = 1'b0;
  logic            redirect_taken_i = 1'b0;
  logic [XLEN-1:0] redirect_pc_i = '0;
  logic            lsu_done_i = 1'b0;

  logic [XLEN-1:0] prog [N_PROG];
  logic            resp_taken [N_RESP];
  logic [XLEN-1:0] resp_target [N_RESP];
  int              resp_delay [N_RESP];

  logic [31:0]     lfsr_q = 32'hfe476c0a;
  logic [XLEN-1:0] rd_addr;
  logic            rd_pend = 1'b0;
  logic [1:0]      r_wait;
  int              resp_row = 0;
  logic            resp_pend = 1'b0;
  logic            resp_is_load;
  int              resp_wait;
  inst_class_e     dec_kind;
  int              n_expected = 0;
  int              total_reads = 0;
  logic            chk_done;
  int              data_errs;
  int              proto_errs;
  int              ar_count;

  tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

  ifu_top u_dut (
    .clk              (clk),
    .rst              (rst),
    .araddr_o         (araddr_o),
    .arvalid_o        (arvalid_o),
    .arready_i        (arready_i),
    .rdata_i          (rdata_i),
    .rvalid_i         (rvalid_i),
    .rready_o         (rready_o),
    .dec_valid_o      (dec_valid_o),
    .dec_ready_i      (dec_ready_i),
    .dec_pc_o         (dec_pc_o),
    .dec_inst_o       (dec_inst_o),
    .redirect_valid_i (redirect_valid_i),
    .redirect_taken_i (redirect_taken_i),
    .redirect_pc_i    (redirect_pc_i),
    .lsu_done_i       (lsu_done_i)
  );

  tb_ifu_checker u_checker (
    .clk              (clk),
    .rst              (rst),
    .dec_valid_i      (dec_valid_o),
    .dec_ready_i      (dec_ready_i),
    .dec_pc_i         (dec_pc_o),
    .dec_inst_i       (dec_inst_o),
    .araddr_i         (araddr_o),
    .arvalid_i        (arvalid_o),
    .arready_i        (arready_i),
    .rvalid_i         (rvalid_i),
    .rready_i         (rready_o),
    .redirect_valid_i (redirect_valid_i),
    .lsu_done_i       (lsu_done_i),
    .done_o           (chk_done),
    .data_errs_o      (data_errs),
    .proto_errs_o     (proto_errs),
    .ar_count_o       (ar_count)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // addi fill word outside the program mixes the whole address
  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    if (addr >= PC_INIT && addr < PC_INIT + 32'd64) begin
      return prog[addr[5:2]];
    end
    return {addr[31:7] ^ addr[24:0], 7'h13};
  endfunction

  assign dec_kind = u_checker.classify(dec_inst_o);

  // axi4-lite slave and random decode ready
  always @(posedge clk) begin
    if (rst) begin
      arready_i <= 1'b0;
      rvalid_i <= 1'b0;
      dec_ready_i <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      dec_ready_i <= (take_bits(2) != 0);
      if (rvalid_i && rready_o) begin
        rvalid_i <= 1'b0;
      end
      if (arvalid_o && arready_i) begin
        rd_addr <= araddr_o;
        rd_pend <= 1'b1;
        r_wait <= 2'(take_bits(2));
        arready_i <= 1'b0;
      end else if (arvalid_o && !rd_pend) begin
        arready_i <= (take_bits(1) != 0);
      end else begin
        arready_i <= 1'b0;
      end
      if (rd_pend && !rvalid_i) begin
        if (r_wait == 2'd0) begin
          rvalid_i <= 1'b1;
          rdata_i <= mem_word(rd_addr);
          rd_pend <= 1'b0;
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
    end
  end

  // execute and load unit stand-in
  always @(posedge clk) begin
    if (rst) begin
      redirect_valid_i <= 1'b0;
      lsu_done_i <= 1'b0;
      resp_pend <= 1'b0;
      resp_row <= 0;
    end else begin
      redirect_valid_i <= 1'b0;
      lsu_done_i <= 1'b0;
      if (resp_pend) begin
        if (resp_wait == 0) begin
          resp_pend <= 1'b0;
          resp_row <= resp_row + 1;
          if (resp_is_load) begin
            lsu_done_i <= 1'b1;
          end else begin
            redirect_valid_i <= 1'b1;
            redirect_taken_i <= resp_taken[resp_row];
            redirect_pc_i <= resp_target[resp_row];
          end
        end else begin
          resp_wait <= resp_wait - 1;
        end
      end else if (dec_valid_o && dec_ready_i && resp_row < N_RESP &&
                   (dec_kind == CLASS_CTRL || dec_kind == CLASS_LOAD)) begin
        resp_pend <= 1'b1;
        resp_wait <= resp_delay[resp_row];
        resp_is_load <= (dec_kind == CLASS_LOAD);
      end
    end
  end

  task automatic load_tables();
    prog[0] = 32'h00100093;
    prog[1] = 32'h00200113;
    prog[2] = 32'h0000a183;
    prog[3] = 32'h00120213;
    prog[4] = 32'hfe0008e3;
    prog[5] = INST_FENCE_I;
    prog[6] = 32'h00128293;
    prog[7] = 32'h0000006f;
    prog[8] = 32'h00130313;
    prog[9] = 32'h00138393;
    prog[10] = 32'h00140413;
    prog[11] = 32'h00148493;
    prog[12] = 32'h00000073;
    prog[13] = 32'h00150513;
    prog[14] = 32'h0000a583;
    prog[15] = 32'h00158593;
    // taken, target, delay per stalling instruction in stream order
    resp_taken = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
    resp_target = '{32'h0, PC_INIT, 32'h0, 32'h0, PC_INIT + 32'd8, 32'h0, 32'h0,
                    PC_INIT + 32'd40, 32'h0};
    resp_delay = '{3, 5, 0, 2, 1, 7, 0, 4, 6};
  endtask

  // walk the program with the fetch rules and a model of the cache
  task automatic build_expected();
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic [3:0]      cvalid;
    logic [26:0]     ctag [4];
    int              row;
    int              reads;
    logic            stop;
    string           name;
    pc = PC_INIT;
    cvalid = '0;
    row = 0;
    reads = 0;
    stop = 1'b0;
    name = "reset_start";
    while (!stop && n_expected < 64) begin
      if (pc < PC_INIT || pc >= PC_INIT + 32'd64) begin
        stop = 1'b1;
      end else begin
        if (!(cvalid[pc[4:3]] && ctag[pc[4:3]] == pc[31:5])) begin
          reads += 2;
          cvalid[pc[4:3]] = 1'b1;
          ctag[pc[4:3]] = pc[31:5];
        end
        inst = prog[pc[5:2]];
        u_checker.add_expected(pc, inst, name);
        n_expected++;
        case (u_checker.classify(inst))
          CLASS_CTRL: begin
            if (row < N_RESP) begin
              pc = resp_taken[row] ? resp_target[row] : pc + 32'd4;
              row++;
              name = "after_redirect";
            end else begin
              stop = 1'b1;
            end
          end
          CLASS_LOAD: begin
            if (row < N_RESP) begin
              pc = pc + 32'd4;
              row++;
              name = "after_load";
            end else begin
              stop = 1'b1;
            end
          end
          CLASS_FENCE: begin
            cvalid = '0;
            pc = pc + 32'd4;
            name = "after_fence";
          end
          default: begin
            pc = pc + 32'd4;
            name = "sequential";
          end
        endcase
      end
    end
    total_reads = reads;
    u_checker.set_reads(reads);
  endtask

  initial begin
    load_tables();
    build_expected();
    while (!chk_done) @(posedge clk);
    $display("closing counts: %0d data errors, %0d protocol errors, %0d of %0d bus reads",
             data_errs, proto_errs, ar_count, total_reads);
    if (data_errs == 0 && proto_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (n_expected > 0);
    repeat (400 * n_expected + 16) @(posedge clk);
    $display("watchdog expired before the decode stream was complete");
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== ifu_top.f ====
hw/ifu_pkg.sv
hw/ifu_axil_reader.sv
hw/ifu_icache.sv
hw/ifu_fetch_ctrl.sv
hw/ifu_inst_buffer.sv
hw/ifu_top.sv
verif/tb_clkgen.sv
verif/tb_ifu_checker.sv
verif/tb_ifu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ifu testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_ifu -f ifu_top.f --Mdir obj_dir -o tb_ifu_sim \
  && ./obj_dir/tb_ifu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "run passed" && exit 0 \
  || { echo "run failed"; exit 1; }
